// File: verilog.f
hdl/cpu_types_pkg.sv
hdl/dcache.sv
hdl/mem_port.sv
hdl/main_ram.sv
hdl/dcache_top.sv
verif/dcache_checker.sv
verif/tb_dcache.sv

// File: run.sh
#!/bin/sh
# Verilator build of the data cache testbench, then one run

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_dcache -f verilog.f -o tb_dcache \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_dcache)
echo "$sim_out"

echo "$sim_out" | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_halt
    } op_t;

    logic CLK;
    logic nRST;
    logic dmemREN;
    logic dmemWEN;
    logic halt;
    cpu_types_pkg::word_t dmemaddr;
    cpu_types_pkg::word_t dmemstore;
    logic dhit;
    logic flushed;
    cpu_types_pkg::word_t dmemload;

    // current test as seen by the checker
    int test_id;
    cpu_types_pkg::word_t exp_load;
    logic exp_first;

    int errors;
    int tests_done;
    int timeout_cycles = 0;
    int cycle_count;
    int entry;

    // stimulus table
    op_t tab_op [$];
    cpu_types_pkg::word_t tab_addr [$];
    logic tab_first [$];
    cpu_types_pkg::word_t tab_data [$];
    cpu_types_pkg::word_t tab_exp [$];

    dcache_top dcache_top_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed)
    );

    dcache_checker check_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmemREN    (dmemREN),
        .dmemWEN    (dmemWEN),
        .halt       (halt),
        .dmemaddr   (dmemaddr),
        .dhit       (dhit),
        .flushed    (flushed),
        .dmemload   (dmemload),
        .test_id    (test_id),
        .exp_load   (exp_load),
        .exp_first  (exp_first),
        .errors     (errors),
        .tests_done (tests_done)
    );

    function automatic cpu_types_pkg::word_t xorshift32(input cpu_types_pkg::word_t x);
        cpu_types_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void add_entry(input op_t op, input cpu_types_pkg::word_t addr,
                                      input logic first);
        tab_op.push_back(op);
        tab_addr.push_back(addr);
        tab_first.push_back(first);
        tab_data.push_back('0);
        tab_exp.push_back('0);
    endfunction

    // sets 1 and 2 carry three blocks each
    function automatic void build_table();
        add_entry(op_store, 32'h0000_0008, 1'b0);
        add_entry(op_load,  32'h0000_0008, 1'b1);
        add_entry(op_store, 32'h0000_0048, 1'b0);
        add_entry(op_load,  32'h0000_0008, 1'b1);
        // evicts the dirty 0x48 block
        add_entry(op_store, 32'h0000_0088, 1'b0);
        add_entry(op_load,  32'h0000_0048, 1'b0);
        add_entry(op_store, 32'h0000_0010, 1'b0);
        add_entry(op_store, 32'h0000_0014, 1'b1);
        add_entry(op_store, 32'h0000_0050, 1'b0);
        add_entry(op_store, 32'h0000_0090, 1'b0);
        add_entry(op_load,  32'h0000_0010, 1'b0);
        add_entry(op_load,  32'h0000_0014, 1'b1);
        add_entry(op_load,  32'h0000_0008, 1'b0);
        add_entry(op_halt,  32'h0000_0000, 1'b0);
        // cache is empty again, every load misses
        add_entry(op_load,  32'h0000_0008, 1'b0);
        add_entry(op_load,  32'h0000_0048, 1'b0);
        add_entry(op_load,  32'h0000_0088, 1'b0);
        add_entry(op_load,  32'h0000_0010, 1'b0);
        add_entry(op_load,  32'h0000_0050, 1'b0);
        add_entry(op_load,  32'h0000_0090, 1'b0);
        add_entry(op_load,  32'h0000_0014, 1'b0);
        add_entry(op_load,  cpu_types_pkg::HIT_ADDR, 1'b0);
    endfunction

    // store data and the memory image the loads should see
    function automatic void prepare_expected();
        cpu_types_pkg::word_t shadow [cpu_types_pkg::word_t];
        cpu_types_pkg::word_t seed;
        int first_hits;
        seed = 32'h8381_1568;
        first_hits = 0;
        for (int n = 0; n < tab_op.size(); n++) begin
            case (tab_op[n])
                op_store: begin
                    seed = xorshift32(seed);
                    tab_data[n] = seed;
                    shadow[tab_addr[n]] = seed;
                end
                op_load: begin
                    tab_exp[n] = shadow.exists(tab_addr[n]) ? shadow[tab_addr[n]] : '0;
                end
                default: begin
                    shadow[cpu_types_pkg::HIT_ADDR] = cpu_types_pkg::word_t'(first_hits);
                    first_hits = 0;
                end
            endcase
            if (tab_first[n]) begin
                first_hits = first_hits + 1;
            end
        end
    endfunction

    task automatic apply_entry(input int n);
        begin
            test_id = n;
            exp_load = tab_exp[n];
            exp_first = tab_first[n];
            dmemaddr = tab_addr[n];
            dmemstore = tab_data[n];
            dmemREN = (tab_op[n] == op_load);
            dmemWEN = (tab_op[n] == op_store);
            halt = (tab_op[n] == op_halt);
            @(negedge CLK);
            while (!(halt ? flushed : dhit)) begin
                @(negedge CLK);
            end
            @(posedge CLK);
            #2;
            dmemREN = 1'b0;
            dmemWEN = 1'b0;
            halt = 1'b0;
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        cycle_count = 0;
        wait (timeout_cycles > 0);
        while (cycle_count < timeout_cycles) begin
            @(posedge CLK);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: test %0d did not finish within %0d cycles", test_id, cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        nRST = 1'b0;
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        halt = 1'b0;
        dmemaddr = '0;
        dmemstore = '0;
        test_id = -1;
        exp_load = '0;
        exp_first = 1'b0;
        build_table();
        prepare_expected();
        timeout_cycles = tab_op.size() * 4 * (cpu_types_pkg::MEM_LATENCY + 1) + 200;

        repeat (16) @(posedge CLK);
        #2;
        nRST = 1'b1;
        @(posedge CLK);
        #2;

        for (entry = 0; entry < tab_op.size(); entry++) begin
            apply_entry(entry);
        end
        test_id = -1;
        // idle a few cycles so a late flushed pulse is still caught
        repeat (4) @(posedge CLK);

        if (tests_done != tab_op.size()) begin
            $display("only %0d of %0d tests finished", tests_done, tab_op.size());
        end
        $display("tests %0d, finished %0d, errors %0d", tab_op.size(), tests_done, errors);
        if (errors == 0 && tests_done == tab_op.size()) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_checker (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmemREN,
    input  logic                 dmemWEN,
    input  logic                 halt,
    input  cpu_types_pkg::word_t dmemaddr,
    input  logic                 dhit,
    input  logic                 flushed,
    input  cpu_types_pkg::word_t dmemload,
    input  int                   test_id,
    input  cpu_types_pkg::word_t exp_load,
    input  logic                 exp_first,
    output int                   errors,
    output int                   tests_done
);

    int cur_id;
    int cycle;
    int test_errs;

    task automatic count_error();
        begin
            errors = errors + 1;
            test_errs = test_errs + 1;
        end
    endtask

    task automatic finish_test();
        begin
            tests_done = tests_done + 1;
            $display("test %0d %s at %08h: %s", cur_id,
                     halt ? "halt" : (dmemWEN ? "store" : "load"), dmemaddr,
                     (test_errs == 0) ? "ok" : "failed");
        end
    endtask

    // one call per cycle, sampled mid-cycle
    task automatic check_cycle();
        begin
            if (test_id != cur_id) begin
                cur_id = test_id;
                cycle = 0;
                test_errs = 0;
            end
            if (cur_id < 0) begin
                if (dhit || flushed) begin
                    $display("dhit or flushed raised with no request pending");
                    errors = errors + 1;
                end
            end else begin
                if (flushed && !halt) begin
                    $display("test %0d: flushed pulse during a load or store", cur_id);
                    count_error();
                end
                if (halt && flushed) begin
                    finish_test();
                end else if (dhit) begin
                    if (exp_first && cycle != 0) begin
                        $display("test %0d: missed on first look, a hit was expected", cur_id);
                        count_error();
                    end
                    if (!exp_first && cycle == 0) begin
                        $display("test %0d: hit on first look, a miss was expected", cur_id);
                        count_error();
                    end
                    if (dmemREN && dmemload !== exp_load) begin
                        $display("mismatch dmemload test %0d: got %08h expected %08h",
                                 cur_id, dmemload, exp_load);
                        count_error();
                    end
                    finish_test();
                end
            end
            cycle = cycle + 1;
        end
    endtask

    initial begin
        errors = 0;
        tests_done = 0;
        cur_id = -1;
        cycle = 0;
        test_errs = 0;
        forever begin
            @(negedge CLK);
            if (nRST) begin
                check_cycle();
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmemREN,
    input  logic                 dmemWEN,
    input  cpu_types_pkg::word_t dmemaddr,
    input  cpu_types_pkg::word_t dmemstore,
    input  logic                 halt,
    output logic                 dhit,
    output cpu_types_pkg::word_t dmemload,
    output logic                 flushed
);

    // cache to memory port
    logic dREN;
    logic dWEN;
    logic dwait;
    cpu_types_pkg::word_t daddr;
    cpu_types_pkg::word_t dstore;
    cpu_types_pkg::word_t dload;

    // memory port to ram
    logic ram_ren;
    logic ram_wen;
    cpu_types_pkg::ram_addr_t ram_addr;
    cpu_types_pkg::word_t ram_wdata;
    cpu_types_pkg::word_t ram_rdata;

    dcache dcache_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .halt      (halt),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dhit      (dhit),
        .flushed   (flushed),
        .dmemload  (dmemload),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dwait     (dwait),
        .dload     (dload)
    );

    mem_port mem_port_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dwait     (dwait),
        .dload     (dload),
        .ram_ren   (ram_ren),
        .ram_wen   (ram_wen),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    main_ram main_ram_i (
        .CLK       (CLK),
        .ram_ren   (ram_ren),
        .ram_wen   (ram_wen),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/main_ram.sv
`timescale 1ns/1ns
`default_nettype none

module main_ram (
    input  logic                     CLK,
    input  logic                     ram_ren,
    input  logic                     ram_wen,
    input  cpu_types_pkg::ram_addr_t ram_addr,
    input  cpu_types_pkg::word_t     ram_wdata,
    output cpu_types_pkg::word_t     ram_rdata
);

    cpu_types_pkg::word_t mem [cpu_types_pkg::RAM_WORDS];

    always_ff @(posedge CLK) begin
        if (ram_wen) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // read port only drives while enabled
    assign ram_rdata = ram_ren ? mem[ram_addr] : '0;

endmodule

`default_nettype wire

// File: hdl/mem_port.sv
`timescale 1ns/1ns
`default_nettype none

module mem_port (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     dREN,
    input  logic                     dWEN,
    input  cpu_types_pkg::word_t     daddr,
    input  cpu_types_pkg::word_t     dstore,
    output logic                     dwait,
    output cpu_types_pkg::word_t     dload,
    output logic                     ram_ren,
    output logic                     ram_wen,
    output cpu_types_pkg::ram_addr_t ram_addr,
    output cpu_types_pkg::word_t     ram_wdata,
    input  cpu_types_pkg::word_t     ram_rdata
);

    logic [cpu_types_pkg::MEM_CNT_W-1:0] wait_cnt;
    logic req;
    logic last;

    assign req = dREN | dWEN;

    // count reached the latency, this cycle completes the word
    assign last = (wait_cnt == cpu_types_pkg::MEM_CNT_W'(cpu_types_pkg::MEM_LATENCY));

    assign dwait = req && !last;
    assign ram_ren = dREN && last;
    assign ram_wen = dWEN && last;

    // word index, byte offset dropped
    assign ram_addr = daddr[cpu_types_pkg::RAM_AW+1:2];
    assign ram_wdata = dstore;
    assign dload = ram_rdata;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!req || last) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmemREN,
    input  logic                 dmemWEN,
    input  logic                 halt,
    input  cpu_types_pkg::word_t dmemaddr,
    input  cpu_types_pkg::word_t dmemstore,
    output logic                 dhit,
    output logic                 flushed,
    output cpu_types_pkg::word_t dmemload,
    output logic                 dREN,
    output logic                 dWEN,
    output cpu_types_pkg::word_t daddr,
    output cpu_types_pkg::word_t dstore,
    input  logic                 dwait,
    input  cpu_types_pkg::word_t dload
);

    cpu_types_pkg::dstate_t state;
    cpu_types_pkg::dstate_t next_state;

    // per way, per set
    logic [1:0][cpu_types_pkg::NUM_SETS-1:0] valid;
    logic [1:0][cpu_types_pkg::NUM_SETS-1:0] dirty;
    cpu_types_pkg::tag_t tags [2][cpu_types_pkg::NUM_SETS];
    cpu_types_pkg::word_t data [2][cpu_types_pkg::NUM_SETS][2];

    // lru bit names the way to replace next
    logic [cpu_types_pkg::NUM_SETS-1:0] lru;

    cpu_types_pkg::word_t hit_count;
    cpu_types_pkg::word_t next_daddr;

    // halt walk position, one extra bit to reach NUM_SETS
    logic [$clog2(cpu_types_pkg::NUM_SETS):0] scan_idx;
    logic halt_way;
    cpu_types_pkg::idx_t scan_set;

    cpu_types_pkg::tag_t req_tag;
    cpu_types_pkg::idx_t req_idx;
    cpu_types_pkg::blkoff_t req_off;

    logic req;
    logic hit0;
    logic hit1;
    logic hit_any;
    logic hit_way;
    logic victim;
    logic miss_start;
    logic done;

    assign req_tag = dmemaddr[31:6];
    assign req_idx = dmemaddr[5:3];
    assign req_off = dmemaddr[2];
    assign scan_set = cpu_types_pkg::idx_t'(scan_idx);

    assign req = dmemREN | dmemWEN;
    assign hit0 = valid[0][req_idx] && (tags[0][req_idx] == req_tag);
    assign hit1 = valid[1][req_idx] && (tags[1][req_idx] == req_tag);
    assign hit_any = hit0 | hit1;
    assign hit_way = hit1;
    assign victim = lru[req_idx];

    // word on the memory side completes
    assign done = !dwait;

    assign dhit = (state == cpu_types_pkg::tag_check) && !halt && req && hit_any;
    assign miss_start = (state == cpu_types_pkg::tag_check) && !halt && req && !hit_any;
    assign dmemload = data[hit_way][req_idx][req_off];
    assign flushed = (state == cpu_types_pkg::flush_done);

    always_comb begin
        next_state = state;
        next_daddr = daddr;
        dREN = 1'b0;
        dWEN = 1'b0;
        dstore = '0;
        case (state)
            cpu_types_pkg::tag_check: begin
                if (halt) begin
                    next_state = cpu_types_pkg::halt_scan;
                end else if (miss_start) begin
                    if (dirty[victim][req_idx]) begin
                        next_state = cpu_types_pkg::wb1;
                        next_daddr = {tags[victim][req_idx], req_idx, 1'b0, 2'b00};
                    end else begin
                        next_state = cpu_types_pkg::al1;
                        next_daddr = {req_tag, req_idx, 1'b0, 2'b00};
                    end
                end
            end
            // victim write-back, word 0 then word 1
            cpu_types_pkg::wb1: begin
                dWEN = 1'b1;
                dstore = data[victim][req_idx][0];
                if (done) begin
                    next_state = cpu_types_pkg::wb2;
                    next_daddr = {tags[victim][req_idx], req_idx, 1'b1, 2'b00};
                end
            end
            cpu_types_pkg::wb2: begin
                dWEN = 1'b1;
                dstore = data[victim][req_idx][1];
                if (done) begin
                    next_state = cpu_types_pkg::al1;
                    next_daddr = {req_tag, req_idx, 1'b0, 2'b00};
                end
            end
            // block fill
            cpu_types_pkg::al1: begin
                dREN = 1'b1;
                if (done) begin
                    next_state = cpu_types_pkg::al2;
                    next_daddr = {req_tag, req_idx, 1'b1, 2'b00};
                end
            end
            cpu_types_pkg::al2: begin
                dREN = 1'b1;
                if (done) begin
                    next_state = cpu_types_pkg::tag_check;
                end
            end
            cpu_types_pkg::halt_scan: begin
                if (scan_idx == cpu_types_pkg::NUM_SETS) begin
                    next_state = cpu_types_pkg::hit_store;
                    next_daddr = cpu_types_pkg::HIT_ADDR;
                end else if (dirty[halt_way][scan_set]) begin
                    next_state = cpu_types_pkg::halt_wb1;
                    next_daddr = {tags[halt_way][scan_set], scan_set, 1'b0, 2'b00};
                end
            end
            cpu_types_pkg::halt_wb1: begin
                dWEN = 1'b1;
                dstore = data[halt_way][scan_set][0];
                if (done) begin
                    next_state = cpu_types_pkg::halt_wb2;
                    next_daddr = {tags[halt_way][scan_set], scan_set, 1'b1, 2'b00};
                end
            end
            cpu_types_pkg::halt_wb2: begin
                dWEN = 1'b1;
                dstore = data[halt_way][scan_set][1];
                if (done) begin
                    next_state = cpu_types_pkg::halt_scan;
                end
            end
            cpu_types_pkg::hit_store: begin
                dWEN = 1'b1;
                dstore = hit_count;
                if (done) begin
                    next_state = cpu_types_pkg::flush_done;
                end
            end
            cpu_types_pkg::flush_done: begin
                next_state = cpu_types_pkg::tag_check;
            end
            default: begin
                next_state = cpu_types_pkg::tag_check;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= cpu_types_pkg::tag_check;
            daddr <= '0;
            valid <= '0;
            dirty <= '0;
            lru <= '0;
            hit_count <= '0;
            scan_idx <= '0;
            halt_way <= 1'b0;
        end else begin
            state <= next_state;
            daddr <= next_daddr;

            // a miss costs one now and earns it back on the final hit
            if (dhit) begin
                hit_count <= hit_count + 32'd1;
                lru[req_idx] <= ~hit_way;
                if (dmemWEN) begin
                    dirty[hit_way][req_idx] <= 1'b1;
                end
            end else if (miss_start) begin
                hit_count <= hit_count - 32'd1;
            end

            case (state)
                cpu_types_pkg::tag_check: begin
                    if (halt) begin
                        scan_idx <= '0;
                        halt_way <= 1'b0;
                    end
                end
                cpu_types_pkg::wb2: begin
                    if (done) begin
                        valid[victim][req_idx] <= 1'b0;
                        dirty[victim][req_idx] <= 1'b0;
                    end
                end
                cpu_types_pkg::al2: begin
                    if (done) begin
                        valid[victim][req_idx] <= 1'b1;
                    end
                end
                cpu_types_pkg::halt_scan: begin
                    // step to next way, then next set
                    if (scan_idx != cpu_types_pkg::NUM_SETS && !dirty[halt_way][scan_set]) begin
                        halt_way <= ~halt_way;
                        if (halt_way) begin
                            scan_idx <= scan_idx + 1'b1;
                        end
                    end
                end
                cpu_types_pkg::halt_wb2: begin
                    if (done) begin
                        dirty[halt_way][scan_set] <= 1'b0;
                    end
                end
                cpu_types_pkg::flush_done: begin
                    valid <= '0;
                    dirty <= '0;
                    lru <= '0;
                    hit_count <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // tags and data words
    always_ff @(posedge CLK) begin
        if (dhit && dmemWEN) begin
            data[hit_way][req_idx][req_off] <= dmemstore;
        end
        if (state == cpu_types_pkg::al1 && done) begin
            data[victim][req_idx][0] <= dload;
        end
        if (state == cpu_types_pkg::al2 && done) begin
            data[victim][req_idx][1] <= dload;
            tags[victim][req_idx] <= req_tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    // cache geometry
    localparam int NUM_SETS = 8;

    // wait cycles per memory word
    localparam int MEM_LATENCY = 2;
    localparam int MEM_CNT_W = $clog2(MEM_LATENCY + 2);

    // data memory size in words
    localparam int RAM_WORDS = 4096;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    typedef logic [31:0] word_t;

    // the hit count lands here at the end of a halt
    localparam word_t HIT_ADDR = 32'h0000_3100;

    // address fields: tag 31:6, index 5:3, block offset 2
    typedef logic [25:0] tag_t;
    typedef logic [$clog2(NUM_SETS)-1:0] idx_t;
    typedef logic blkoff_t;

    typedef logic [RAM_AW-1:0] ram_addr_t;

    typedef enum logic [3:0] {
        tag_check,
        wb1,
        wb2,
        al1,
        al2,
        halt_scan,
        halt_wb1,
        halt_wb2,
        hit_store,
        flush_done
    } dstate_t;

endpackage

`default_nettype wire
